// File: Bender.yml
package:
  name: local_mem

dependencies: {}

sources:
  # Design, package first
  - files:
      - hw/local_mem_pkg.sv
      - hw/local_mem_reg_pipe.sv
      - hw/local_mem_bank.sv
      - hw/local_mem_bank_route.sv
      - hw/local_mem_as_avalon.sv

  # Testbench
  - target: simulation
    files:
      - dv/local_mem_checker.sv
      - dv/local_mem_tb.sv

// File: dv/local_mem_checker.sv
/*
 * Response checker for the local-memory testbench. The stimulus pushes the
 * expected word of every accepted read, and each readdatavalid pops one entry.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_checker
(
    input  wire logic                                             tgt_mem_afu_clk,
    input  wire logic                                             rst,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]   readdata,
    input  wire logic                                             readdatavalid,
    output int                                                    mismatch_count,
    output int                                                    unexpected_count
);

    import local_mem_pkg::*;

    // Expected read data in issue order
    logic [LOCAL_MEM_DATA_WIDTH-1:0] expected_q [$];
    logic [LOCAL_MEM_DATA_WIDTH-1:0] head_value;
    int                              mismatches = 0;
    int                              unexpected = 0;

    assign mismatch_count   = mismatches;
    assign unexpected_count = unexpected;

    // ==================================================
    // Queue access for the stimulus
    // ==================================================

    // Called once per read, at the edge where the DUT accepts it
    task automatic push_expected(input logic [LOCAL_MEM_DATA_WIDTH-1:0] value);
        expected_q.push_back(value);
    endtask

    // Reads still waiting for their data
    function automatic int pending();
        return expected_q.size();
    endfunction

    // ==================================================
    // Response compare
    // ==================================================
    // The AFU-side response is registered in the pipe, so it is settled at the falling edge
    always @(negedge tgt_mem_afu_clk)
    begin
        if (!rst && readdatavalid === 1'b1)
        begin
            if (expected_q.size() == 0)
            begin
                unexpected++;
                $display("ERROR readdatavalid went high with no read outstanding at %0t ns",
                         $time);
            end
            else
            begin
                head_value = expected_q.pop_front();
                if (readdata !== head_value)
                begin
                    mismatches++;
                    $display("FAIL readdata expected 0x%08h got 0x%08h", head_value, readdata);
                end
            end
        end
        // A stuck or undriven valid is as bad as a wrong word
        else if (!rst && readdatavalid !== 1'b0)
        begin
            unexpected++;
            $display("ERROR readdatavalid is neither high nor low at %0t ns", $time);
        end
    end

endmodule

`default_nettype wire

// File: dv/local_mem_input.txt
// Columns: op (1 digit), address (3 digits), write data (8 digits), expected read data (8 digits)
// Op 1 is a read, 2 a write, 5 and 6 the same with 0 to 3 random idle cycles first; 0 ends
// Write then read one word
6_005_CAFE0005_00000000
5_005_00000000_CAFE0005
// Consecutive addresses alternate between the banks
2_020_A0000020_00000000
2_021_A0000021_00000000
2_022_A0000022_00000000
2_023_A0000023_00000000
2_024_A0000024_00000000
2_025_A0000025_00000000
2_026_A0000026_00000000
2_027_A0000027_00000000
// Back-to-back reads that alternate banks return in issue order
1_020_00000000_A0000020
1_021_00000000_A0000021
1_022_00000000_A0000022
1_023_00000000_A0000023
1_024_00000000_A0000024
1_025_00000000_A0000025
1_026_00000000_A0000026
1_027_00000000_A0000027
// Back-to-back writes to bank 0 stall on write recovery
2_040_B0000040_00000000
2_042_B0000042_00000000
2_044_B0000044_00000000
2_046_B0000046_00000000
2_048_B0000048_00000000
// Mixed reads with random gaps
5_046_00000000_B0000046
5_040_00000000_B0000040
5_048_00000000_B0000048
5_042_00000000_B0000042
5_044_00000000_B0000044
5_027_00000000_A0000027
5_022_00000000_A0000022
5_005_00000000_CAFE0005
// Overwrite one word and read around it
6_022_D0000022_00000000
5_022_00000000_D0000022
1_023_00000000_A0000023
1_022_00000000_D0000022
0_000_00000000_00000000

// File: dv/local_mem_tb.sv
/*
 * Testbench for the local-memory port. Replays the requests of the input file
 * on the AFU Avalon slave and lets the checker compare the read responses.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_tb;

    import local_mem_pkg::*;

    logic                              tgt_mem_afu_clk;
    logic                              rst;
    logic [LOCAL_MEM_ADDR_WIDTH-1:0]   address;
    logic                              read;
    logic                              write;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]   writedata;
    logic                              waitrequest;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]   readdata;
    logic                              readdatavalid;
    int                                mismatch_count;
    int                                unexpected_count;

    // One line per request: op[79:76], address[75:64], write data[63:32], expected[31:0]
    logic [79:0]                       stim [0:63];
    int                                timeout_errors;
    bit                                timed_out;

    // 40 ns clock period
    initial
    begin
        tgt_mem_afu_clk = 1'b0;
        forever #20 tgt_mem_afu_clk = ~tgt_mem_afu_clk;
    end

    local_mem_as_avalon local_mem_as_avalon_inst
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .rst             (rst),
        .address         (address),
        .read            (read),
        .write           (write),
        .writedata       (writedata),
        .waitrequest     (waitrequest),
        .readdata        (readdata),
        .readdatavalid   (readdatavalid)
    );

    local_mem_checker resp_check
    (
        .tgt_mem_afu_clk  (tgt_mem_afu_clk),
        .rst              (rst),
        .readdata         (readdata),
        .readdatavalid    (readdatavalid),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count)
    );

    // Idle the bus for a number of cycles, entered just after a rising edge
    task automatic idle_gap(input int cycles);
        #2;
        read  = 1'b0;
        write = 1'b0;
        repeat (cycles) @(posedge tgt_mem_afu_clk);
    endtask

    // Present one request and hold it until an edge sees waitrequest low
    task automatic issue_request(input logic [79:0] line);
        int cycles;
        bit accepted;
        bit stalled;
        cycles   = 0;
        accepted = 1'b0;
        #2;
        address   = line[64 +: LOCAL_MEM_ADDR_WIDTH];
        writedata = line[63:32];
        read      = (line[77:76] == CMD_READ);
        write     = (line[77:76] == CMD_WRITE);
        while (!accepted && cycles < 1000)
        begin
            // Waitrequest is registered, so the falling edge shows what the next edge sees
            @(negedge tgt_mem_afu_clk);
            stalled = (waitrequest !== 1'b0);
            @(posedge tgt_mem_afu_clk);
            accepted = !stalled;
            cycles++;
        end
        if (!accepted)
        begin
            $display("ERROR request to address 0x%03h was never accepted", line[75:64]);
            timeout_errors++;
            timed_out = 1'b1;
        end
        else if (line[77:76] == CMD_READ)
        begin
            resp_check.push_expected(line[31:0]);
        end
    endtask

    initial
    begin : main_flow
        int idx;
        int cycles;
        int gap;
        rst            = 1'b1;
        address        = '0;
        read           = 1'b0;
        write          = 1'b0;
        writedata      = '0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        idx            = 0;
        void'($urandom(32'h5447));
        for (int i = 0; i < 64; i++)
        begin
            stim[i] = '0;
        end
        $readmemh("dv/local_mem_input.txt", stim);

        repeat (10) @(posedge tgt_mem_afu_clk);
        #2;
        rst = 1'b0;
        @(posedge tgt_mem_afu_clk);

        // ==================================================
        // Replay the file, op 0 marks the end
        // ==================================================
        while (idx < 64 && !timed_out && stim[idx][79:76] != 4'h0)
        begin
            // Bit 2 of the op asks for 0 to 3 idle cycles first
            if (stim[idx][78])
            begin
                gap = $urandom % 4;
                if (gap > 0)
                begin
                    idle_gap(gap);
                end
            end
            issue_request(stim[idx]);
            idx++;
        end
        idle_gap(0);

        // Every read must come back before the queue timeout
        cycles = 0;
        while (resp_check.pending() != 0 && cycles < 1000)
        begin
            @(posedge tgt_mem_afu_clk);
            cycles++;
        end
        if (resp_check.pending() != 0)
        begin
            $display("ERROR %0d reads never returned data", resp_check.pending());
            timeout_errors++;
        end
        // A few quiet cycles catch any extra readdatavalid
        repeat (10) @(posedge tgt_mem_afu_clk);

        $display("Errors: %0d mismatches, %0d unexpected responses, %0d timeouts",
                 mismatch_count, unexpected_count, timeout_errors);
        if (mismatch_count + unexpected_count + timeout_errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/local_mem_pkg.sv
hw/local_mem_reg_pipe.sv
hw/local_mem_bank.sv
hw/local_mem_bank_route.sv
hw/local_mem_as_avalon.sv
dv/local_mem_checker.sv
dv/local_mem_tb.sv

// File: hw/local_mem_as_avalon.sv
/*
 * Top level of the local-memory port. Exports an Avalon-MM slave to the AFU and
 * connects the timing pipe, the bank router and two interleaved banks.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_as_avalon
(
    input  wire logic                                             tgt_mem_afu_clk,
    input  wire logic                                             rst,

    // AFU Avalon-MM slave, one word per request
    input  wire logic [local_mem_pkg::LOCAL_MEM_ADDR_WIDTH-1:0]   address,
    input  wire logic                                             read,
    input  wire logic                                             write,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]   writedata,
    output logic                                                  waitrequest,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]        readdata,
    output logic                                                  readdatavalid
);

    import local_mem_pkg::*;

    mem_cmd_e                             afu_cmd;

    // Pipe to router
    mem_cmd_e                             pipe_cmd;
    logic [LOCAL_MEM_ADDR_WIDTH-1:0]      pipe_address;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      pipe_writedata;
    logic                                 route_waitrequest;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      route_readdata;
    logic                                 route_readdatavalid;

    // Router to banks
    mem_cmd_e                             b0_cmd;
    logic [LOCAL_MEM_BANK_ADDR_WIDTH-1:0] b0_address;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      b0_writedata;
    logic                                 b0_waitrequest;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      b0_readdata;
    logic                                 b0_readdatavalid;
    mem_cmd_e                             b1_cmd;
    logic [LOCAL_MEM_BANK_ADDR_WIDTH-1:0] b1_address;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      b1_writedata;
    logic                                 b1_waitrequest;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]      b1_readdata;
    logic                                 b1_readdatavalid;

    // Avalon read and write are exclusive, so the encoding is a simple priority
    assign afu_cmd = read ? CMD_READ : (write ? CMD_WRITE : CMD_IDLE);

    // ==================================================
    // Timing stages on the AFU side
    // ==================================================
    local_mem_reg_pipe
    #(
        .N_REG_STAGES (LOCAL_MEM_REG_STAGES)
    )
    mem_pipe
    (
        .tgt_mem_afu_clk  (tgt_mem_afu_clk),
        .rst              (rst),
        .up_cmd           (afu_cmd),
        .up_address       (address),
        .up_writedata     (writedata),
        .up_waitrequest   (waitrequest),
        .up_readdata      (readdata),
        .up_readdatavalid (readdatavalid),
        .dn_cmd           (pipe_cmd),
        .dn_address       (pipe_address),
        .dn_writedata     (pipe_writedata),
        .dn_waitrequest   (route_waitrequest),
        .dn_readdata      (route_readdata),
        .dn_readdatavalid (route_readdatavalid)
    );

    // ==================================================
    // Bank steering and the two banks
    // ==================================================
    local_mem_bank_route bank_route
    (
        .cmd              (pipe_cmd),
        .address          (pipe_address),
        .writedata        (pipe_writedata),
        .waitrequest      (route_waitrequest),
        .readdata         (route_readdata),
        .readdatavalid    (route_readdatavalid),
        .b0_cmd           (b0_cmd),
        .b0_address       (b0_address),
        .b0_writedata     (b0_writedata),
        .b0_waitrequest   (b0_waitrequest),
        .b0_readdata      (b0_readdata),
        .b0_readdatavalid (b0_readdatavalid),
        .b1_cmd           (b1_cmd),
        .b1_address       (b1_address),
        .b1_writedata     (b1_writedata),
        .b1_waitrequest   (b1_waitrequest),
        .b1_readdata      (b1_readdata),
        .b1_readdatavalid (b1_readdatavalid),
        .tgt_mem_afu_clk  (tgt_mem_afu_clk),
        .rst              (rst)
    );

    local_mem_bank bank0
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .rst             (rst),
        .cmd             (b0_cmd),
        .address         (b0_address),
        .writedata       (b0_writedata),
        .waitrequest     (b0_waitrequest),
        .readdata        (b0_readdata),
        .readdatavalid   (b0_readdatavalid)
    );

    local_mem_bank bank1
    (
        .tgt_mem_afu_clk (tgt_mem_afu_clk),
        .rst             (rst),
        .cmd             (b1_cmd),
        .address         (b1_address),
        .writedata       (b1_writedata),
        .waitrequest     (b1_waitrequest),
        .readdata        (b1_readdata),
        .readdatavalid   (b1_readdatavalid)
    );

endmodule

`default_nettype wire

// File: hw/local_mem_bank.sv
/*
 * One interleaved memory bank with a fixed, pipelined read latency.
 * An accepted write costs one cycle of recovery shown on waitrequest.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_bank
(
    input  wire logic                                                tgt_mem_afu_clk,
    input  wire logic                                                rst,

    input  wire local_mem_pkg::mem_cmd_e                             cmd,
    input  wire logic [local_mem_pkg::LOCAL_MEM_BANK_ADDR_WIDTH-1:0] address,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]      writedata,
    output logic                                                     waitrequest,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]           readdata,
    output logic                                                     readdatavalid
);

    import local_mem_pkg::*;

    // Word storage for this bank
    logic [LOCAL_MEM_DATA_WIDTH-1:0] mem [0:(2**LOCAL_MEM_BANK_ADDR_WIDTH)-1];

    // High for the single cycle after an accepted write
    logic                                wr_recover;
    logic                                wr_accept;
    logic                                rd_accept;

    // Read return pipeline, one slot per cycle of latency
    logic [LOCAL_MEM_BANK_READ_LATENCY-1:0] rd_valid;
    logic [LOCAL_MEM_DATA_WIDTH-1:0]        rd_data [0:LOCAL_MEM_BANK_READ_LATENCY-1];

    assign waitrequest = wr_recover;
    assign wr_accept   = (cmd == CMD_WRITE) && !wr_recover;
    assign rd_accept   = (cmd == CMD_READ) && !wr_recover;

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (rst)
        begin
            wr_recover <= 1'b0;
            rd_valid   <= '0;
        end
        else
        begin
            // A write is never back to back with another command in this bank
            wr_recover  <= wr_accept;
            rd_valid[0] <= rd_accept;
            for (int i = 1; i < LOCAL_MEM_BANK_READ_LATENCY; i++)
            begin
                rd_valid[i] <= rd_valid[i-1];
            end
        end
    end

    // ==================================================
    // Storage and read data
    // ==================================================
    always_ff @(posedge tgt_mem_afu_clk)
    begin
        if (wr_accept)
        begin
            mem[address] <= writedata;
        end
        // The array is read every cycle and only the valid slot counts
        rd_data[0] <= mem[address];
        for (int i = 1; i < LOCAL_MEM_BANK_READ_LATENCY; i++)
        begin
            rd_data[i] <= rd_data[i-1];
        end
    end

    assign readdatavalid = rd_valid[LOCAL_MEM_BANK_READ_LATENCY-1];
    assign readdata      = rd_data[LOCAL_MEM_BANK_READ_LATENCY-1];

    // Each accepted read comes back after the fixed latency, which the router
    // relies on to keep responses in issue order
    a_read_latency : assert property (
        @(posedge tgt_mem_afu_clk) disable iff (rst)
        rd_accept |-> ##LOCAL_MEM_BANK_READ_LATENCY readdatavalid
    );

endmodule

`default_nettype wire

// File: hw/local_mem_bank_route.sv
/*
 * Steers each request to one of two banks by the interleave bit and merges the
 * banks' read responses into one stream. Purely combinational for data.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_bank_route
(
    // Upstream request from the pipe
    input  wire local_mem_pkg::mem_cmd_e                             cmd,
    input  wire logic [local_mem_pkg::LOCAL_MEM_ADDR_WIDTH-1:0]      address,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]      writedata,
    output logic                                                     waitrequest,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]           readdata,
    output logic                                                     readdatavalid,

    // Bank 0, even word addresses
    output local_mem_pkg::mem_cmd_e                                  b0_cmd,
    output logic [local_mem_pkg::LOCAL_MEM_BANK_ADDR_WIDTH-1:0]      b0_address,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]           b0_writedata,
    input  wire logic                                                b0_waitrequest,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]      b0_readdata,
    input  wire logic                                                b0_readdatavalid,

    // Bank 1, odd word addresses
    output local_mem_pkg::mem_cmd_e                                  b1_cmd,
    output logic [local_mem_pkg::LOCAL_MEM_BANK_ADDR_WIDTH-1:0]      b1_address,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]           b1_writedata,
    input  wire logic                                                b1_waitrequest,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]      b1_readdata,
    input  wire logic                                                b1_readdatavalid,

    // Only used by the collision check
    input  wire logic                                                tgt_mem_afu_clk,
    input  wire logic                                                rst
);

    import local_mem_pkg::*;

    logic                                 bank_sel;
    logic [LOCAL_MEM_BANK_ADDR_WIDTH-1:0] bank_address;

    // ==================================================
    // Request steering
    // ==================================================
    assign bank_sel = address[LOCAL_MEM_BANK_SEL_BIT];

    // The select bit is the lowest one, so the bank address is the bits above it
    assign bank_address = address[LOCAL_MEM_ADDR_WIDTH-1:LOCAL_MEM_BANK_SEL_BIT+1];

    // Only the selected bank sees the command, the other one idles
    assign b0_cmd = bank_sel ? CMD_IDLE : cmd;
    assign b1_cmd = bank_sel ? cmd : CMD_IDLE;

    // Address and data fan out to both, the command decides who acts
    assign b0_address   = bank_address;
    assign b1_address   = bank_address;
    assign b0_writedata = writedata;
    assign b1_writedata = writedata;

    // Stall follows the bank that this request targets
    assign waitrequest = bank_sel ? b1_waitrequest : b0_waitrequest;

    // ==================================================
    // Response merge
    // ==================================================
    // Equal bank latency and one accept per cycle keep the banks from ever
    // returning in the same cycle, so a simple select preserves issue order
    assign readdatavalid = b0_readdatavalid || b1_readdatavalid;
    assign readdata      = b1_readdatavalid ? b1_readdata : b0_readdata;

    a_no_rsp_collision : assert property (
        @(posedge tgt_mem_afu_clk) disable iff (rst)
        !(b0_readdatavalid && b1_readdatavalid)
    );

endmodule

`default_nettype wire

// File: hw/local_mem_pkg.sv
/*
 * Shared constants and types for the AFU local-memory port.
 * Imported by the pipe, the bank router, the banks and the top level.
 */

`default_nettype none

package local_mem_pkg;

    // ==================================================
    // Address and data geometry
    // ==================================================

    // Word address as seen by the AFU
    localparam int LOCAL_MEM_ADDR_WIDTH = 10;

    // One data word per request, no byte enables
    localparam int LOCAL_MEM_DATA_WIDTH = 32;

    // Bit 0 picks the bank, so consecutive words alternate between banks
    localparam int LOCAL_MEM_BANK_SEL_BIT = 0;

    // The bank sees the full address minus its select bit
    localparam int LOCAL_MEM_BANK_ADDR_WIDTH = LOCAL_MEM_ADDR_WIDTH - 1;

    // ==================================================
    // Latency
    // ==================================================

    // Edges from a bank accepting a read to that bank's readdatavalid
    localparam int LOCAL_MEM_BANK_READ_LATENCY = 2;

    // Timing stages between the AFU and the router.
    // Each one adds a cycle on the request side and a cycle on the response side
    localparam int LOCAL_MEM_REG_STAGES = 2;

    // Command carried on every internal hop in place of read and write strobes
    typedef enum logic [1:0]
    {
        CMD_IDLE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } mem_cmd_e;

endpackage

`default_nettype wire

// File: hw/local_mem_reg_pipe.sv
/*
 * Timing register stages between the AFU and the bank router.
 * Every request stage is a skid stage that honors waitrequest. Responses are
 * delayed by the same number of stages. With zero stages the block is wires.
 */

`timescale 1ns/1ns
`default_nettype none

module local_mem_reg_pipe
#(
    parameter int N_REG_STAGES = 1
)
(
    input  wire logic                                             tgt_mem_afu_clk,
    input  wire logic                                             rst,

    // Upstream side, toward the AFU
    input  wire local_mem_pkg::mem_cmd_e                          up_cmd,
    input  wire logic [local_mem_pkg::LOCAL_MEM_ADDR_WIDTH-1:0]   up_address,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]   up_writedata,
    output logic                                                  up_waitrequest,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]        up_readdata,
    output logic                                                  up_readdatavalid,

    // Downstream side, toward the router
    output local_mem_pkg::mem_cmd_e                               dn_cmd,
    output logic [local_mem_pkg::LOCAL_MEM_ADDR_WIDTH-1:0]        dn_address,
    output logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]        dn_writedata,
    input  wire logic                                             dn_waitrequest,
    input  wire logic [local_mem_pkg::LOCAL_MEM_DATA_WIDTH-1:0]   dn_readdata,
    input  wire logic                                             dn_readdatavalid
);

    import local_mem_pkg::*;

    // Request chain. Index 0 is the upstream side and index N the downstream side.
    // With no stages the two ends are the same element and the pipe reduces to wires
    mem_cmd_e                          req_cmd       [0:N_REG_STAGES];
    logic [LOCAL_MEM_ADDR_WIDTH-1:0]   req_address   [0:N_REG_STAGES];
    logic [LOCAL_MEM_DATA_WIDTH-1:0]   req_writedata [0:N_REG_STAGES];
    logic                              req_wait      [0:N_REG_STAGES];

    // Response chain, indexed the same way but flowing toward index 0
    logic                              rsp_valid     [0:N_REG_STAGES];
    logic [LOCAL_MEM_DATA_WIDTH-1:0]   rsp_data      [0:N_REG_STAGES];

    assign req_cmd[0]       = up_cmd;
    assign req_address[0]   = up_address;
    assign req_writedata[0] = up_writedata;
    assign up_waitrequest   = req_wait[0];

    assign dn_cmd                 = req_cmd[N_REG_STAGES];
    assign dn_address             = req_address[N_REG_STAGES];
    assign dn_writedata           = req_writedata[N_REG_STAGES];
    assign req_wait[N_REG_STAGES] = dn_waitrequest;

    assign rsp_valid[N_REG_STAGES] = dn_readdatavalid;
    assign rsp_data[N_REG_STAGES]  = dn_readdata;
    assign up_readdatavalid        = rsp_valid[0];
    assign up_readdata             = rsp_data[0];

    // ==================================================
    // Request stages
    // ==================================================
    for (genvar i = 0; i < N_REG_STAGES; i++)
    begin : g_req_stage
        // Main register drives the next stage, skid catches one request on a stall
        mem_cmd_e                          main_cmd;
        logic [LOCAL_MEM_ADDR_WIDTH-1:0]   main_address;
        logic [LOCAL_MEM_DATA_WIDTH-1:0]   main_writedata;
        mem_cmd_e                          skid_cmd;
        logic [LOCAL_MEM_ADDR_WIDTH-1:0]   skid_address;
        logic [LOCAL_MEM_DATA_WIDTH-1:0]   skid_writedata;
        logic                              skid_valid;
        logic                              take_in;
        logic                              main_free;

        // The waitrequest sent upstream is the registered skid flag, which
        // breaks the combinational waitrequest path at every stage
        assign take_in   = (req_cmd[i] != CMD_IDLE) && !skid_valid;
        assign main_free = (main_cmd == CMD_IDLE) || !req_wait[i+1];

        always_ff @(posedge tgt_mem_afu_clk)
        begin
            if (rst)
            begin
                main_cmd   <= CMD_IDLE;
                skid_valid <= 1'b0;
            end
            else if (main_free)
            begin
                // A parked request always goes first to keep issue order.
                // With the skid empty, an idle input loads CMD_IDLE as it should
                main_cmd   <= skid_valid ? skid_cmd : req_cmd[i];
                skid_valid <= 1'b0;
            end
            else if (take_in)
            begin
                skid_valid <= 1'b1;
            end
        end

        always_ff @(posedge tgt_mem_afu_clk)
        begin
            if (main_free)
            begin
                main_address   <= skid_valid ? skid_address : req_address[i];
                main_writedata <= skid_valid ? skid_writedata : req_writedata[i];
            end
            // Main is held downstream, so the newly accepted request parks here
            if (!main_free && take_in)
            begin
                skid_cmd       <= req_cmd[i];
                skid_address   <= req_address[i];
                skid_writedata <= req_writedata[i];
            end
        end

        assign req_cmd[i+1]       = main_cmd;
        assign req_address[i+1]   = main_address;
        assign req_writedata[i+1] = main_writedata;
        assign req_wait[i]        = skid_valid;
    end

    // ==================================================
    // Response stages
    // ==================================================
    for (genvar i = 0; i < N_REG_STAGES; i++)
    begin : g_rsp_stage
        logic                              valid_q;
        logic [LOCAL_MEM_DATA_WIDTH-1:0]   data_q;

        // No back-pressure on responses, so this is a plain shift stage
        always_ff @(posedge tgt_mem_afu_clk)
        begin
            if (rst)
            begin
                valid_q <= 1'b0;
            end
            else
            begin
                valid_q <= rsp_valid[i+1];
            end
        end

        always_ff @(posedge tgt_mem_afu_clk)
        begin
            data_q <= rsp_data[i+1];
        end

        assign rsp_valid[i] = valid_q;
        assign rsp_data[i]  = data_q;
    end

    // The AFU must hold a stalled command until it is taken
    a_up_cmd_stable : assert property (
        @(posedge tgt_mem_afu_clk) disable iff (rst)
        (up_cmd != CMD_IDLE) && up_waitrequest |=> up_cmd == $past(up_cmd)
    );

endmodule

`default_nettype wire
